// ==== lutram_store_pkg.sv ====
`default_nettype none

package lutram_store_pkg;

    // ==================================================
    // Store geometry
    // ==================================================
    localparam int DATA_WIDTH     = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int STRB_WIDTH     = DATA_WIDTH / BYTE_WIDTH;
    localparam int NUM_SET        = 64;
    localparam int SET_ADDR_WIDTH = $clog2(NUM_SET);

    // ==================================================
    // Bus side
    // ==================================================
    localparam int ADDR_WIDTH = 9;
    localparam int CTRL_BIT   = 8;                     // Set for control region

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;
    typedef logic [SET_ADDR_WIDTH-1:0] set_addr_t;
    typedef logic [ADDR_WIDTH-1:0]     axi_addr_t;
    typedef logic [1:0]                resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== lutram_port_if.sv ====
`default_nettype none

interface lutram_port_if;

    logic                         access_en;
    lutram_store_pkg::strb_t      write_en;        // Zero on a read
    lutram_store_pkg::set_addr_t  set_addr;
    lutram_store_pkg::word_t      write_entry;
    lutram_store_pkg::word_t      read_entry;      // Combinational
    logic                         read_valid;      // One cycle behind access_en

    modport ctrl
    (
        output access_en,
        output write_en,
        output set_addr,
        output write_entry,
        input  read_entry,
        input  read_valid
    );

    modport store
    (
        input  access_en,
        input  write_en,
        input  set_addr,
        input  write_entry,
        output read_entry,
        output read_valid
    );

endinterface

`default_nettype wire

// ==== flush_if.sv ====
`default_nettype none

interface flush_if;

    logic                         start;           // Single cycle pulse
    logic                         busy;
    lutram_store_pkg::set_addr_t  index;           // Entry cleared this cycle
    logic                         done;

    modport ctrl
    (
        output start,
        input  done
    );

    modport counter
    (
        input  start,
        output busy,
        output index,
        output done
    );

    modport store
    (
        input  busy,
        input  index
    );

endinterface

`default_nettype wire

// ==== single_port_lutram.sv ====
`default_nettype none

module single_port_lutram
(
    input  logic           clk_in,
    input  logic           reset_in,

    lutram_port_if.store   port,
    flush_if.store         flush
);

    lutram_store_pkg::word_t                      lut_ram [lutram_store_pkg::NUM_SET];
    logic [lutram_store_pkg::NUM_SET-1:0]         valid_array;

    // ==================================================
    // Data array
    // ==================================================
    always_ff @(posedge clk_in)
    begin
        if (port.access_en)
        begin
            for (int lane = 0; lane < lutram_store_pkg::STRB_WIDTH; lane++)
            begin
                if (port.write_en[lane])
                begin
                    lut_ram[port.set_addr][lane*lutram_store_pkg::BYTE_WIDTH +:
                                           lutram_store_pkg::BYTE_WIDTH]
                        <= port.write_entry[lane*lutram_store_pkg::BYTE_WIDTH +:
                                            lutram_store_pkg::BYTE_WIDTH];
                end
            end
        end
    end

    assign port.read_entry = port.access_en ? lut_ram[port.set_addr] : '0;

    // ==================================================
    // Valid bits
    // ==================================================
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            valid_array     <= '0;
            port.read_valid <= 1'b0;
        end
        else
        begin
            if (flush.busy)
            begin
                valid_array[flush.index] <= 1'b0;      // Sweep clear
            end

            if (port.access_en && (|port.write_en))
            begin
                valid_array[port.set_addr] <= 1'b1;
            end

            if (port.access_en)
            begin
                port.read_valid <= valid_array[port.set_addr];
            end
            else
            begin
                port.read_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== flush_counter.sv ====
`default_nettype none

module flush_counter
(
    input  logic        clk_in,
    input  logic        reset_in,

    flush_if.counter    flush
);

    // Walks index 0 to NUM_SET-1 at one entry per cycle
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            flush.busy  <= 1'b0;
            flush.index <= '0;
            flush.done  <= 1'b0;
        end
        else
        begin
            flush.done <= 1'b0;

            if (flush.busy)
            begin
                flush.index <= flush.index + 1'b1;     // Wraps back to zero

                if (flush.index == lutram_store_pkg::set_addr_t'(
                        lutram_store_pkg::NUM_SET - 1))
                begin
                    flush.busy <= 1'b0;
                    flush.done <= 1'b1;                // Last entry cleared
                end
            end
            else if (flush.start)
            begin
                flush.busy  <= 1'b1;
                flush.index <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== axil_ctrl_fsm.sv ====
`default_nettype none

module axil_ctrl_fsm
(
    input  logic                         clk_in,
    input  logic                         reset_in,

    input  lutram_store_pkg::axi_addr_t  awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  lutram_store_pkg::word_t      wdata,
    input  lutram_store_pkg::strb_t      wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output lutram_store_pkg::resp_t      bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  lutram_store_pkg::axi_addr_t  araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output lutram_store_pkg::word_t      rdata,
    output lutram_store_pkg::resp_t      rresp,
    output logic                         rvalid,
    input  logic                         rready,

    lutram_port_if.ctrl                  port,
    flush_if.ctrl                        flush
);

    typedef enum logic [2:0]
    {
        IDLE,
        WRITE_RESP,
        FLUSH_WAIT,
        READ_WAIT,
        READ_RESP
    } state_t;

    state_t                       state;
    logic                         read_phase;      // Second READ_WAIT cycle
    logic                         write_hs;
    logic                         read_hs;
    logic                         mem_write;
    lutram_store_pkg::set_addr_t  set_addr_q;
    lutram_store_pkg::word_t      wdata_q;
    lutram_store_pkg::strb_t      wstrb_q;

    // ==================================================
    // Handshakes and store drive
    // ==================================================
    assign write_hs = (state == IDLE) && awvalid && wvalid;
    assign read_hs  = (state == IDLE) && !awvalid && !wvalid && arvalid;

    assign awready = write_hs;
    assign wready  = write_hs;
    assign arready = (state == IDLE) && !awvalid && !wvalid;  // Writes win
    assign bresp   = lutram_store_pkg::RESP_OKAY;

    // First WRITE_RESP cycle after a memory write commits the data
    assign mem_write        = (state == WRITE_RESP) && !bvalid;
    assign port.access_en   = mem_write || (state == READ_WAIT);
    assign port.write_en    = mem_write ? wstrb_q : '0;
    assign port.set_addr    = set_addr_q;
    assign port.write_entry = wdata_q;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state       <= IDLE;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            read_phase  <= 1'b0;
            flush.start <= 1'b0;
        end
        else
        begin
            flush.start <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (write_hs)
                    begin
                        if (awaddr[lutram_store_pkg::CTRL_BIT])
                        begin
                            flush.start <= 1'b1;
                            state       <= FLUSH_WAIT;
                        end
                        else
                        begin
                            state <= WRITE_RESP;
                        end
                    end
                    else if (read_hs)
                    begin
                        if (araddr[lutram_store_pkg::CTRL_BIT])
                        begin
                            rvalid <= 1'b1;                // SLVERR right away
                            state  <= READ_RESP;
                        end
                        else
                        begin
                            read_phase <= 1'b0;
                            state      <= READ_WAIT;
                        end
                    end
                end

                WRITE_RESP:
                begin
                    if (!bvalid)
                    begin
                        bvalid <= 1'b1;
                    end
                    else if (bready)
                    begin
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end

                FLUSH_WAIT:
                begin
                    if (flush.done)
                    begin
                        bvalid <= 1'b1;
                        state  <= WRITE_RESP;
                    end
                end

                READ_WAIT:
                begin
                    read_phase <= 1'b1;
                    if (read_phase)
                    begin
                        rvalid <= 1'b1;
                        state  <= READ_RESP;
                    end
                end

                READ_RESP:
                begin
                    if (rready)
                    begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Request and response payload
    // ==================================================
    always_ff @(posedge clk_in)
    begin
        if (write_hs)
        begin
            set_addr_q <= awaddr[2 +: lutram_store_pkg::SET_ADDR_WIDTH];  // Skip byte offset
            wdata_q    <= wdata;
            wstrb_q    <= wstrb;
        end
        else if (read_hs)
        begin
            set_addr_q <= araddr[2 +: lutram_store_pkg::SET_ADDR_WIDTH];
        end

        if (read_hs && araddr[lutram_store_pkg::CTRL_BIT])
        begin
            rdata <= '0;
            rresp <= lutram_store_pkg::RESP_SLVERR;
        end
        else if ((state == READ_WAIT) && read_phase)
        begin
            rdata <= port.read_valid ? port.read_entry : '0;
            rresp <= port.read_valid ? lutram_store_pkg::RESP_OKAY
                                     : lutram_store_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== axil_lutram_store.sv ====
`default_nettype none

module axil_lutram_store
(
    input  logic                         clk_in,
    input  logic                         reset_in,

    // Write address and data
    input  lutram_store_pkg::axi_addr_t  s_awaddr,
    input  logic                         s_awvalid,
    output logic                         s_awready,
    input  lutram_store_pkg::word_t      s_wdata,
    input  lutram_store_pkg::strb_t      s_wstrb,
    input  logic                         s_wvalid,
    output logic                         s_wready,

    // Write response
    output lutram_store_pkg::resp_t      s_bresp,
    output logic                         s_bvalid,
    input  logic                         s_bready,

    // Read address and data
    input  lutram_store_pkg::axi_addr_t  s_araddr,
    input  logic                         s_arvalid,
    output logic                         s_arready,
    output lutram_store_pkg::word_t      s_rdata,
    output lutram_store_pkg::resp_t      s_rresp,
    output logic                         s_rvalid,
    input  logic                         s_rready
);

    lutram_port_if  port_bus ();
    flush_if        flush_bus ();

    // ==================================================
    // Bus slave and store
    // ==================================================
    axil_ctrl_fsm u_ctrl
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .awaddr   (s_awaddr),
        .awvalid  (s_awvalid),
        .awready  (s_awready),
        .wdata    (s_wdata),
        .wstrb    (s_wstrb),
        .wvalid   (s_wvalid),
        .wready   (s_wready),
        .bresp    (s_bresp),
        .bvalid   (s_bvalid),
        .bready   (s_bready),
        .araddr   (s_araddr),
        .arvalid  (s_arvalid),
        .arready  (s_arready),
        .rdata    (s_rdata),
        .rresp    (s_rresp),
        .rvalid   (s_rvalid),
        .rready   (s_rready),
        .port     (port_bus),
        .flush    (flush_bus)
    );

    flush_counter u_flush
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .flush    (flush_bus)
    );

    single_port_lutram u_store
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .port     (port_bus),
        .flush    (flush_bus)
    );

endmodule

`default_nettype wire

// ==== tb_checks.svh ====
// ==================================================
// Compare tasks
// ==================================================
task automatic check_word(input string name, input lutram_store_pkg::word_t expected,
                          input lutram_store_pkg::word_t actual);
    begin
        if (actual !== expected)
        begin
            $display("Fail %s: data expected %08h, actual %08h", name, expected, actual);
            test_errors++;
        end
    end
endtask

task automatic check_resp(input string name, input lutram_store_pkg::resp_t expected,
                          input lutram_store_pkg::resp_t actual);
    begin
        if (actual !== expected)
        begin
            $display("Fail %s: resp expected %0d, actual %0d", name, expected, actual);
            test_errors++;
        end
    end
endtask

// Holds the response back 0 to 5 cycles and checks that it stays put
task automatic hold_response(input string name, input bit is_read,
                             input lutram_store_pkg::word_t data_seen,
                             input lutram_store_pkg::resp_t resp_seen);
    int delay;
    begin
        delay = {$random(seed)} % 6;
        repeat (delay)
        begin
            @(negedge clk_in);
            if (is_read && (!rvalid || rdata !== data_seen || rresp !== resp_seen))
            begin
                $display("Read response of %s changed before RREADY was given", name);
                test_errors++;
            end
            if (!is_read && (!bvalid || bresp !== resp_seen))
            begin
                $display("Write response of %s changed before BREADY was given", name);
                test_errors++;
            end
            if (awready || wready || arready)
            begin
                $display("A READY output rose while the response of %s was pending", name);
                test_errors++;
            end
        end
    end
endtask

// ==================================================
// AXI4-Lite master tasks
// ==================================================
task automatic axil_write(input string name, input lutram_store_pkg::axi_addr_t addr,
                          input lutram_store_pkg::word_t data,
                          input lutram_store_pkg::strb_t strb,
                          output lutram_store_pkg::resp_t resp);
    int cycles;
    begin
        resp = 'x;
        @(negedge clk_in);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        cycles  = 0;
        #1;                                            // Let READY settle
        while (!(awready && wready) && cycles < wait_limit)
        begin
            @(negedge clk_in);
            #1;
            cycles++;
        end
        if (!(awready && wready))
        begin
            $display("Write address and data handshake of %s never completed", name);
            test_errors++;
            awvalid = 1'b0;
            wvalid  = 1'b0;
            return;
        end
        @(posedge clk_in);
        @(negedge clk_in);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        while (!bvalid && cycles < wait_limit)
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!bvalid)
        begin
            $display("No write response arrived for %s", name);
            test_errors++;
            return;
        end
        resp = bresp;
        hold_response(name, 1'b0, '0, resp);
        bready = 1'b1;
        @(negedge clk_in);
        bready = 1'b0;
        if (bvalid)
        begin
            $display("BVALID of %s stayed high after BREADY", name);
            test_errors++;
        end
    end
endtask

task automatic axil_read(input string name, input lutram_store_pkg::axi_addr_t addr,
                         output lutram_store_pkg::word_t data,
                         output lutram_store_pkg::resp_t resp);
    int cycles;
    begin
        data = 'x;
        resp = 'x;
        @(negedge clk_in);
        araddr  = addr;
        arvalid = 1'b1;
        cycles  = 0;
        #1;
        while (!arready && cycles < wait_limit)
        begin
            @(negedge clk_in);
            #1;
            cycles++;
        end
        if (!arready)
        begin
            $display("Read address handshake of %s never completed", name);
            test_errors++;
            arvalid = 1'b0;
            return;
        end
        @(posedge clk_in);
        @(negedge clk_in);
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid && cycles < wait_limit)
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!rvalid)
        begin
            $display("No read response arrived for %s", name);
            test_errors++;
            return;
        end
        data = rdata;
        resp = rresp;
        hold_response(name, 1'b1, data, resp);
        rready = 1'b1;
        @(negedge clk_in);
        rready = 1'b0;
        if (rvalid)
        begin
            $display("RVALID of %s stayed high after RREADY", name);
            test_errors++;
        end
    end
endtask

// ==== tb_axil_lutram_store.sv ====
`default_nettype none

module tb_axil_lutram_store;

    typedef enum {OP_WRITE, OP_READ, OP_FLUSH} op_t;

    logic                         clk_in = 1'b0;
    logic                         reset_in;
    lutram_store_pkg::axi_addr_t  awaddr;
    logic                         awvalid;
    logic                         awready;
    lutram_store_pkg::word_t      wdata;
    lutram_store_pkg::strb_t      wstrb;
    logic                         wvalid;
    logic                         wready;
    lutram_store_pkg::resp_t      bresp;
    logic                         bvalid;
    logic                         bready;
    lutram_store_pkg::axi_addr_t  araddr;
    logic                         arvalid;
    logic                         arready;
    lutram_store_pkg::word_t      rdata;
    lutram_store_pkg::resp_t      rresp;
    logic                         rvalid;
    logic                         rready;

    int seed        = 7658;
    int wait_limit  = lutram_store_pkg::NUM_SET + 20;  // Cycles per handshake or row
    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    bit table_ready = 1'b0;

    // Test table with one entry per row in each queue
    string                        row_name [$];
    op_t                          row_op [$];
    lutram_store_pkg::axi_addr_t  row_addr [$];
    lutram_store_pkg::word_t      row_data [$];
    lutram_store_pkg::strb_t      row_strb [$];
    lutram_store_pkg::word_t      row_exp_data [$];
    lutram_store_pkg::resp_t      row_exp_resp [$];

    lutram_store_pkg::word_t      shadow [lutram_store_pkg::NUM_SET];
    bit                           shadow_valid [lutram_store_pkg::NUM_SET];
    lutram_store_pkg::word_t      got_data;
    lutram_store_pkg::resp_t      got_resp;

    `include "tb_checks.svh"

    axil_lutram_store UUT
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .s_awaddr  (awaddr),
        .s_awvalid (awvalid),
        .s_awready (awready),
        .s_wdata   (wdata),
        .s_wstrb   (wstrb),
        .s_wvalid  (wvalid),
        .s_wready  (wready),
        .s_bresp   (bresp),
        .s_bvalid  (bvalid),
        .s_bready  (bready),
        .s_araddr  (araddr),
        .s_arvalid (arvalid),
        .s_arready (arready),
        .s_rdata   (rdata),
        .s_rresp   (rresp),
        .s_rvalid  (rvalid),
        .s_rready  (rready)
    );

    always #20 clk_in = ~clk_in;

    // Appends a row and works out its expected result from the shadow memory
    task automatic add_row(input string name, input op_t op,
                           input lutram_store_pkg::axi_addr_t addr,
                           input lutram_store_pkg::word_t data,
                           input lutram_store_pkg::strb_t strb);
        lutram_store_pkg::set_addr_t  idx;
        lutram_store_pkg::word_t      exp_data;
        lutram_store_pkg::resp_t      exp_resp;
        begin
            idx      = addr[2 +: lutram_store_pkg::SET_ADDR_WIDTH];
            exp_data = '0;
            exp_resp = lutram_store_pkg::RESP_OKAY;
            if (op == OP_FLUSH)
            begin
                for (int i = 0; i < lutram_store_pkg::NUM_SET; i++)
                begin
                    shadow_valid[i] = 1'b0;
                end
            end
            else if (op == OP_WRITE)
            begin
                for (int lane = 0; lane < lutram_store_pkg::STRB_WIDTH; lane++)
                begin
                    if (strb[lane])
                    begin
                        shadow[idx][lane*lutram_store_pkg::BYTE_WIDTH +:
                                    lutram_store_pkg::BYTE_WIDTH]
                            = data[lane*lutram_store_pkg::BYTE_WIDTH +:
                                   lutram_store_pkg::BYTE_WIDTH];
                    end
                end
                shadow_valid[idx] = 1'b1;
            end
            else if (addr[lutram_store_pkg::CTRL_BIT] || !shadow_valid[idx])
            begin
                exp_resp = lutram_store_pkg::RESP_SLVERR;      // Zero data
            end
            else
            begin
                exp_data = shadow[idx];
            end
            row_name.push_back(name);
            row_op.push_back(op);
            row_addr.push_back(addr);
            row_data.push_back(data);
            row_strb.push_back(strb);
            row_exp_data.push_back(exp_data);
            row_exp_resp.push_back(exp_resp);
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial
    begin
        reset_in = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        for (int i = 0; i < lutram_store_pkg::NUM_SET; i++)
        begin
            shadow_valid[i] = 1'b0;
        end

        add_row("read_unwritten_after_reset", OP_READ, 9'h000, '0, '0);
        add_row("write_full_e1", OP_WRITE, 9'h004, $random(seed), 4'hF);
        add_row("read_full_e1", OP_READ, 9'h004, '0, '0);
        add_row("write_full_e2", OP_WRITE, 9'h008, $random(seed), 4'hF);
        add_row("write_strb_0101_e2", OP_WRITE, 9'h008, $random(seed), 4'b0101);
        add_row("read_merge_0101_e2", OP_READ, 9'h008, '0, '0);
        add_row("write_strb_0010_e2", OP_WRITE, 9'h008, $random(seed), 4'b0010);
        add_row("read_merge_0010_e2", OP_READ, 9'h008, '0, '0);
        add_row("write_full_e63", OP_WRITE, 9'h0FC, $random(seed), 4'hF);
        add_row("read_full_e63", OP_READ, 9'h0FC, '0, '0);
        add_row("read_ctrl_base", OP_READ, 9'h100, '0, '0);
        add_row("read_ctrl_top", OP_READ, 9'h1FC, '0, '0);
        add_row("flush", OP_FLUSH, 9'h100, $random(seed), 4'hF);
        add_row("read_e1_after_flush", OP_READ, 9'h004, '0, '0);
        add_row("read_e2_after_flush", OP_READ, 9'h008, '0, '0);
        add_row("read_e63_after_flush", OP_READ, 9'h0FC, '0, '0);
        add_row("read_unwritten_after_flush", OP_READ, 9'h014, '0, '0);
        add_row("rewrite_e1", OP_WRITE, 9'h004, $random(seed), 4'hF);
        add_row("read_rewrite_e1", OP_READ, 9'h004, '0, '0);
        add_row("read_e2_still_invalid", OP_READ, 9'h008, '0, '0);
        table_ready = 1'b1;

        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;

        for (int row = 0; row < row_name.size(); row++)
        begin
            test_errors = 0;
            if (row_op[row] == OP_READ)
            begin
                axil_read(row_name[row], row_addr[row], got_data, got_resp);
                check_word(row_name[row], row_exp_data[row], got_data);
                check_resp(row_name[row], row_exp_resp[row], got_resp);
            end
            else
            begin
                axil_write(row_name[row], row_addr[row], row_data[row], row_strb[row],
                           got_resp);
                check_resp(row_name[row], row_exp_resp[row], got_resp);
            end
            if (test_errors == 0)
            begin
                pass_count++;
                $display("Test %0d %s: ok", row, row_name[row]);
            end
            else
            begin
                fail_count++;
                $display("Test %0d %s: failed", row, row_name[row]);
            end
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

    // ==================================================
    // Watchdog
    // ==================================================
    initial
    begin
        wait (table_ready);
        repeat (row_name.size() * wait_limit) @(posedge clk_in);
        $display("Watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
lutram_store_pkg.sv
lutram_port_if.sv
flush_if.sv
single_port_lutram.sv
flush_counter.sv
axil_ctrl_fsm.sv
axil_lutram_store.sv
tb_axil_lutram_store.sv

// ==== Makefile ====
# Verilator build for the AXI4-Lite LUTRAM store

VERILATOR ?= verilator
TOP       ?= tb_axil_lutram_store
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
